//--- Bender.yml
package:
  name: core

sources:
  - common/core_pkg.sv
  - rtl/fetch_stage.sv
  - decode/decode_stage.sv
  - decode/reg_file.sv
  - rtl/hazard_unit.sv
  - rtl/execute_stage.sv
  - rtl/mem_stage.sv
  - rtl/core_top.sv
  - target: test
    files:
      - testbench/tb_core.sv

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // Opcode field, zero decodes as NOP
   typedef enum logic [5:0] {
      NOP  = 6'd0,
      HALT = 6'd1,
      ADD  = 6'd2,
      SUB  = 6'd3,
      AND  = 6'd4,
      XOR  = 6'd5,
      ADDI = 6'd6,
      LDW  = 6'd7,
      LDH  = 6'd8,
      LDB  = 6'd9,
      STW  = 6'd10,
      STH  = 6'd11,
      STB  = 6'd12
   } op_t;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_t;

   typedef enum logic [1:0] {
      GRAN_WORD = 2'd0,
      GRAN_HALF = 2'd1,
      GRAN_BYTE = 2'd2
   } gran_t;

   // Instruction field positions
   localparam int OP_LSB = 26;
   localparam int RS_LSB = 21;
   localparam int RT_LSB = 16;
   localparam int RD_LSB = 11;

   localparam int NUM_REGS = 32;
   localparam int PC_STEP  = 4;

   // Big-endian lane masks before the address shift
   localparam logic [3:0] LANE_WORD = 4'b1111;
   localparam logic [3:0] LANE_HALF = 4'b1100;
   localparam logic [3:0] LANE_BYTE = 4'b1000;

endpackage

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
   input  wire logic            clk,
   input  wire logic            rst_n,
   input  core_pkg::word_t      if_id_inst_i,
   input  wire logic            bubble_i,
   input  core_pkg::word_t      rs_data_i,
   input  core_pkg::word_t      rt_data_i,
   output core_pkg::reg_idx_t   rs_o,
   output core_pkg::reg_idx_t   rt_o,
   output logic                 err_o,
   output logic                 id_halt_o,
   output core_pkg::op_t        ex_op_o,
   output core_pkg::alu_op_t    ex_alu_op_o,
   output core_pkg::gran_t      ex_gran_o,
   output core_pkg::word_t      ex_a_o,
   output core_pkg::word_t      ex_b_o,
   output core_pkg::word_t      ex_imm_o,
   output core_pkg::reg_idx_t   ex_rs_o,
   output core_pkg::reg_idx_t   ex_rt_o,
   output core_pkg::reg_idx_t   ex_rd_o,
   output logic                 ex_load_o,
   output logic                 ex_store_o,
   output logic                 ex_wr_o,
   output logic                 ex_halt_o
);

   import core_pkg::*;

   op_t      op;
   op_t      dec_op;
   logic     illegal;
   alu_op_t  alu_op;
   gran_t    gran;
   logic     use_rd;
   logic     is_load;
   logic     is_store;
   logic     is_wr;
   reg_idx_t dest;
   word_t    imm;

   assign rs_o = if_id_inst_i[RS_LSB +: 5];
   assign rt_o = if_id_inst_i[RT_LSB +: 5];
   assign imm  = {{16{if_id_inst_i[15]}}, if_id_inst_i[15:0]};

   //////////////////////////////////////////////////////////////////////
   // Opcode decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      op      = op_t'(if_id_inst_i[OP_LSB +: 6]);
      illegal = 1'b0;
      alu_op  = ALU_ADD;
      gran    = GRAN_WORD;
      case (op)
         NOP, HALT, ADD, ADDI, LDW, STW: begin
         end
         SUB: alu_op = ALU_SUB;
         AND: alu_op = ALU_AND;
         XOR: alu_op = ALU_XOR;
         LDH, STH: gran = GRAN_HALF;
         LDB, STB: gran = GRAN_BYTE;
         default: illegal = 1'b1;
      endcase
      use_rd   = op inside {ADD, SUB, AND, XOR};
      is_load  = op inside {LDW, LDH, LDB};
      is_store = op inside {STW, STH, STB};
      is_wr    = use_rd || is_load || op == ADDI;
      // Undefined opcodes travel on as NOP
      dec_op   = illegal ? NOP : op;
      // rd for register format, rt otherwise
      if (!is_wr) begin
         dest = '0;
      end else if (use_rd) begin
         dest = if_id_inst_i[RD_LSB +: 5];
      end else begin
         dest = if_id_inst_i[RT_LSB +: 5];
      end
   end

   assign id_halt_o = op == HALT;

   // Stalled copy of the same instruction is not counted twice
   assign err_o = illegal && !bubble_i;

   //////////////////////////////////////////////////////////////////////
   // ID/EX register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_op_o    <= NOP;
         ex_rd_o    <= '0;
         ex_load_o  <= 1'b0;
         ex_store_o <= 1'b0;
         ex_wr_o    <= 1'b0;
         ex_halt_o  <= 1'b0;
      end else begin
         // Bubble enters as NOP
         ex_op_o    <= bubble_i ? NOP : dec_op;
         ex_rd_o    <= bubble_i ? '0 : dest;
         ex_load_o  <= is_load && !bubble_i;
         ex_store_o <= is_store && !bubble_i;
         ex_wr_o    <= is_wr && !bubble_i;
         ex_halt_o  <= id_halt_o && !bubble_i;
      end
   end

   // Operands and fields
   always_ff @(posedge clk) begin
      ex_alu_op_o <= alu_op;
      ex_gran_o   <= gran;
      ex_a_o      <= rs_data_i;
      ex_b_o      <= rt_data_i;
      ex_imm_o    <= imm;
      ex_rs_o     <= rs_o;
      ex_rt_o     <= rt_o;
   end

   a_ld_st_excl : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ex_load_o && ex_store_o)
   ) else $error("ID/EX holds both load and store");

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  core_pkg::reg_idx_t rs_i,
   input  core_pkg::reg_idx_t rt_i,
   input  core_pkg::reg_idx_t wr_idx_i,
   input  wire logic          wr_en_i,
   input  core_pkg::word_t    wr_data_i,
   output core_pkg::word_t    rs_data_o,
   output core_pkg::word_t    rt_data_o
);

   import core_pkg::*;

   word_t regs [NUM_REGS];

   // r0 never written, so it stays zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en_i && wr_idx_i != '0) begin
         regs[wr_idx_i] <= wr_data_i;
      end
   end

   // Same-cycle write bypass
   assign rs_data_o = (wr_en_i && wr_idx_i != '0 && wr_idx_i == rs_i) ? wr_data_i : regs[rs_i];
   assign rt_data_o = (wr_en_i && wr_idx_i != '0 && wr_idx_i == rt_i) ? wr_data_i : regs[rt_i];

endmodule

`default_nettype wire

//--- rtl/core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top (
   input  wire logic           clk,
   input  wire logic           rst_n,
   input  core_pkg::word_t     inst_i,
   output core_pkg::word_t     iaddr_o,
   input  core_pkg::word_t     data_i,
   output core_pkg::word_t     daddr_o,
   output logic [3:0]          we_o,
   output logic [3:0]          re_o,
   output core_pkg::word_t     data_o,
   output logic                err_o,
   output logic                halt_o
);

   import core_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // Stage to stage wires
   //////////////////////////////////////////////////////////////////////

   logic     hold;
   logic     bubble;
   word_t    if_id_inst;

   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   word_t    rs_data;
   word_t    rt_data;
   logic     id_halt;

   // ID/EX
   op_t      ex_op;
   alu_op_t  ex_alu_op;
   gran_t    ex_gran;
   word_t    ex_a;
   word_t    ex_b;
   word_t    ex_imm;
   reg_idx_t ex_rs;
   reg_idx_t ex_rt;
   reg_idx_t ex_rd;
   logic     ex_load;
   logic     ex_store;
   logic     ex_wr;
   logic     ex_halt;

   // EX/MEM
   op_t      mem_op;
   gran_t    mem_gran;
   word_t    mem_addr;
   word_t    mem_wdata;
   reg_idx_t mem_rd;
   logic     mem_load;
   logic     mem_store;
   logic     mem_wr;
   logic     mem_halt;

   // MEM/WB
   reg_idx_t wb_idx;
   logic     wb_en;
   word_t    wb_data;
   logic     wb_halt;

   //////////////////////////////////////////////////////////////////////
   // Pipeline
   //////////////////////////////////////////////////////////////////////

   fetch_stage i_fetch (
      .clk          (clk),
      .rst_n        (rst_n),
      .hold_i       (hold),
      .inst_i       (inst_i),
      .iaddr_o      (iaddr_o),
      .if_id_inst_o (if_id_inst)
   );

   decode_stage i_decode (
      .clk          (clk),
      .rst_n        (rst_n),
      .if_id_inst_i (if_id_inst),
      .bubble_i     (bubble),
      .rs_data_i    (rs_data),
      .rt_data_i    (rt_data),
      .rs_o         (rs_idx),
      .rt_o         (rt_idx),
      .err_o        (err_o),
      .id_halt_o    (id_halt),
      .ex_op_o      (ex_op),
      .ex_alu_op_o  (ex_alu_op),
      .ex_gran_o    (ex_gran),
      .ex_a_o       (ex_a),
      .ex_b_o       (ex_b),
      .ex_imm_o     (ex_imm),
      .ex_rs_o      (ex_rs),
      .ex_rt_o      (ex_rt),
      .ex_rd_o      (ex_rd),
      .ex_load_o    (ex_load),
      .ex_store_o   (ex_store),
      .ex_wr_o      (ex_wr),
      .ex_halt_o    (ex_halt)
   );

   reg_file i_reg_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rs_i      (rs_idx),
      .rt_i      (rt_idx),
      .wr_idx_i  (wb_idx),
      .wr_en_i   (wb_en),
      .wr_data_i (wb_data),
      .rs_data_o (rs_data),
      .rt_data_o (rt_data)
   );

   hazard_unit i_hazard (
      .clk          (clk),
      .rst_n        (rst_n),
      .rs_i         (rs_idx),
      .rt_i         (rt_idx),
      .id_ex_load_i (ex_load),
      .id_ex_rd_i   (ex_rd),
      .id_halt_i    (id_halt),
      .wb_halt_i    (wb_halt),
      .hold_o       (hold),
      .bubble_o     (bubble),
      .halt_o       (halt_o)
   );

   execute_stage i_execute (
      .clk         (clk),
      .rst_n       (rst_n),
      .ex_op_i     (ex_op),
      .ex_alu_op_i (ex_alu_op),
      .ex_gran_i   (ex_gran),
      .ex_a_i      (ex_a),
      .ex_b_i      (ex_b),
      .ex_imm_i    (ex_imm),
      .ex_rs_i     (ex_rs),
      .ex_rt_i     (ex_rt),
      .ex_rd_i     (ex_rd),
      .ex_load_i   (ex_load),
      .ex_store_i  (ex_store),
      .ex_wr_i     (ex_wr),
      .ex_halt_i   (ex_halt),
      .wb_idx_i    (wb_idx),
      .wb_en_i     (wb_en),
      .wb_data_i   (wb_data),
      .mem_op_o    (mem_op),
      .mem_gran_o  (mem_gran),
      .mem_addr_o  (mem_addr),
      .mem_wdata_o (mem_wdata),
      .mem_rd_o    (mem_rd),
      .mem_load_o  (mem_load),
      .mem_store_o (mem_store),
      .mem_wr_o    (mem_wr),
      .mem_halt_o  (mem_halt)
   );

   mem_stage i_mem (
      .clk         (clk),
      .rst_n       (rst_n),
      .mem_op_i    (mem_op),
      .mem_gran_i  (mem_gran),
      .mem_addr_i  (mem_addr),
      .mem_wdata_i (mem_wdata),
      .mem_rd_i    (mem_rd),
      .mem_load_i  (mem_load),
      .mem_store_i (mem_store),
      .mem_wr_i    (mem_wr),
      .mem_halt_i  (mem_halt),
      .data_i      (data_i),
      .daddr_o     (daddr_o),
      .data_o      (data_o),
      .we_o        (we_o),
      .re_o        (re_o),
      .wb_idx_o    (wb_idx),
      .wb_en_o     (wb_en),
      .wb_data_o   (wb_data),
      .wb_halt_o   (wb_halt)
   );

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  core_pkg::op_t      ex_op_i,
   input  core_pkg::alu_op_t  ex_alu_op_i,
   input  core_pkg::gran_t    ex_gran_i,
   input  core_pkg::word_t    ex_a_i,
   input  core_pkg::word_t    ex_b_i,
   input  core_pkg::word_t    ex_imm_i,
   input  core_pkg::reg_idx_t ex_rs_i,
   input  core_pkg::reg_idx_t ex_rt_i,
   input  core_pkg::reg_idx_t ex_rd_i,
   input  wire logic          ex_load_i,
   input  wire logic          ex_store_i,
   input  wire logic          ex_wr_i,
   input  wire logic          ex_halt_i,
   input  core_pkg::reg_idx_t wb_idx_i,
   input  wire logic          wb_en_i,
   input  core_pkg::word_t    wb_data_i,
   output core_pkg::op_t      mem_op_o,
   output core_pkg::gran_t    mem_gran_o,
   output core_pkg::word_t    mem_addr_o,
   output core_pkg::word_t    mem_wdata_o,
   output core_pkg::reg_idx_t mem_rd_o,
   output logic               mem_load_o,
   output logic               mem_store_o,
   output logic               mem_wr_o,
   output logic               mem_halt_o
);

   import core_pkg::*;

   word_t a_fwd;
   word_t b_fwd;
   word_t op_b;
   word_t result;

   // EX/MEM first, MEM/WB next, r0 never forwarded
   function automatic word_t fwd(reg_idx_t idx, word_t reg_val);
      if (mem_wr_o && mem_rd_o != '0 && mem_rd_o == idx) begin
         return mem_addr_o;
      end else if (wb_en_i && wb_idx_i != '0 && wb_idx_i == idx) begin
         return wb_data_i;
      end
      return reg_val;
   endfunction

   always_comb begin
      a_fwd = fwd(ex_rs_i, ex_a_i);
      b_fwd = fwd(ex_rt_i, ex_b_i);
   end

   // ADDI and memory ops take the immediate
   assign op_b = (ex_op_i inside {ADD, SUB, AND, XOR}) ? b_fwd : ex_imm_i;

   always_comb begin
      case (ex_alu_op_i)
         ALU_SUB: result = a_fwd - op_b;
         ALU_AND: result = a_fwd & op_b;
         ALU_XOR: result = a_fwd ^ op_b;
         default: result = a_fwd + op_b;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // EX/MEM register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_op_o    <= NOP;
         mem_gran_o  <= GRAN_WORD;
         mem_rd_o    <= '0;
         mem_load_o  <= 1'b0;
         mem_store_o <= 1'b0;
         mem_wr_o    <= 1'b0;
         mem_halt_o  <= 1'b0;
      end else begin
         mem_op_o    <= ex_op_i;
         mem_gran_o  <= ex_gran_i;
         mem_rd_o    <= ex_wr_i ? ex_rd_i : '0;
         mem_load_o  <= ex_load_i;
         mem_store_o <= ex_store_i;
         mem_wr_o    <= ex_wr_i;
         mem_halt_o  <= ex_halt_i;
      end
   end

   // Result doubles as the memory address
   always_ff @(posedge clk) begin
      mem_addr_o  <= result;
      mem_wdata_o <= b_fwd;
   end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       hold_i,
   input  core_pkg::word_t inst_i,
   output core_pkg::word_t iaddr_o,
   output core_pkg::word_t if_id_inst_o
);

   import core_pkg::*;

   // PC and IF/ID move together, both frozen under hold
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         iaddr_o      <= '0;
         // All-zero word is a NOP
         if_id_inst_o <= '0;
      end else if (!hold_i) begin
         iaddr_o      <= iaddr_o + word_t'(PC_STEP);
         if_id_inst_o <= inst_i;
      end
   end

   a_pc_aligned : assert property (
      @(posedge clk) disable iff (!rst_n)
      iaddr_o[1:0] == 2'b00
   ) else $error("fetch address not word-aligned");

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  core_pkg::reg_idx_t rs_i,
   input  core_pkg::reg_idx_t rt_i,
   input  wire logic          id_ex_load_i,
   input  core_pkg::reg_idx_t id_ex_rd_i,
   input  wire logic          id_halt_i,
   input  wire logic          wb_halt_i,
   output logic               hold_o,
   output logic               bubble_o,
   output logic               halt_o
);

   typedef enum logic [1:0] {
      RUN    = 2'd0,
      DRAIN  = 2'd1,
      HALTED = 2'd2
   } state_t;

   state_t state;
   state_t state_nxt;
   logic   load_use;

   // Load result not ready for the instruction right behind it
   assign load_use = id_ex_load_i && id_ex_rd_i != '0 &&
                     (id_ex_rd_i == rs_i || id_ex_rd_i == rt_i);

   //////////////////////////////////////////////////////////////////////
   // Halt FSM
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         // HALT leaves ID only when it is not being stalled
         RUN:     if (id_halt_i && !load_use) state_nxt = DRAIN;
         DRAIN:   if (wb_halt_i) state_nxt = HALTED;
         default: state_nxt = HALTED;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= RUN;
      end else begin
         state <= state_nxt;
      end
   end

   // Once draining, HALT sits in IF/ID and only NOPs go down
   assign bubble_o = load_use || state != RUN;
   assign hold_o   = bubble_o || id_halt_i;
   assign halt_o   = state == HALTED;

   a_halt_sticky : assert property (
      @(posedge clk) disable iff (!rst_n)
      state == HALTED |=> state == HALTED
   ) else $error("left HALTED without reset");

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  core_pkg::op_t      mem_op_i,
   input  core_pkg::gran_t    mem_gran_i,
   input  core_pkg::word_t    mem_addr_i,
   input  core_pkg::word_t    mem_wdata_i,
   input  core_pkg::reg_idx_t mem_rd_i,
   input  wire logic          mem_load_i,
   input  wire logic          mem_store_i,
   input  wire logic          mem_wr_i,
   input  wire logic          mem_halt_i,
   input  core_pkg::word_t    data_i,
   output core_pkg::word_t    daddr_o,
   output core_pkg::word_t    data_o,
   output logic [3:0]         we_o,
   output logic [3:0]         re_o,
   output core_pkg::reg_idx_t wb_idx_o,
   output logic               wb_en_o,
   output core_pkg::word_t    wb_data_o,
   output logic               wb_halt_o
);

   import core_pkg::*;

   logic [1:0] ofs;
   logic [3:0] lanes;
   word_t      st_data;
   word_t      ld_data;
   logic       wb_load;
   word_t      wb_result;
   word_t      wb_ld_data;

   assign ofs = mem_addr_i[1:0];

   // Big-endian lanes, narrow data aligned to the top then shifted
   always_comb begin
      case (mem_gran_i)
         GRAN_HALF: begin
            lanes   = LANE_HALF >> ofs;
            st_data = {mem_wdata_i[15:0], 16'h0000} >> {ofs, 3'b000};
            ld_data = data_i & 32'h0000_ffff;
         end
         GRAN_BYTE: begin
            lanes   = LANE_BYTE >> ofs;
            st_data = {mem_wdata_i[7:0], 24'h00_0000} >> {ofs, 3'b000};
            ld_data = data_i & 32'h0000_00ff;
         end
         default: begin
            lanes   = LANE_WORD;
            st_data = mem_wdata_i;
            ld_data = data_i;
         end
      endcase
   end

   assign daddr_o = mem_addr_i;
   assign data_o  = st_data;
   assign we_o    = mem_store_i ? lanes : 4'b0000;
   assign re_o    = mem_load_i ? lanes : 4'b0000;

   //////////////////////////////////////////////////////////////////////
   // MEM/WB register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_idx_o  <= '0;
         wb_en_o   <= 1'b0;
         wb_load   <= 1'b0;
         wb_halt_o <= 1'b0;
      end else begin
         wb_idx_o  <= mem_rd_i;
         wb_en_o   <= mem_wr_i;
         wb_load   <= mem_load_i;
         wb_halt_o <= mem_halt_i;
      end
   end

   always_ff @(posedge clk) begin
      wb_result  <= mem_addr_i;
      wb_ld_data <= ld_data;
   end

   assign wb_data_o = wb_load ? wb_ld_data : wb_result;

   // Store flag from decode must match a store opcode here
   a_store_op : assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_store_i |-> mem_op_i inside {STW, STH, STB}
   ) else $error("store flag on a non-store opcode");

endmodule

`default_nettype wire

//--- src.f
common/core_pkg.sv
rtl/fetch_stage.sv
decode/decode_stage.sv
decode/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/core_top.sv
testbench/tb_core.sv

//--- testbench/tb_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core;

   import core_pkg::*;

   localparam int          CLK_HALF   = 50;
   localparam logic [31:0] SEED       = 32'd81263;
   localparam int          N_RANDOM   = 120;
   localparam int          DMEM_WORDS = 64;
   localparam int          IMEM_WORDS = 256;
   localparam int          HALT_WATCH = 20;

   logic     clk;
   logic     rst_n;
   word_t    inst_i;
   word_t    iaddr_o;
   word_t    data_i;
   word_t    daddr_o;
   logic [3:0] we_o;
   logic [3:0] re_o;
   word_t    data_o;
   logic     err_o;
   logic     halt_o;

   // Program and memories
   word_t imem [IMEM_WORDS];
   int    prog_len;
   int    halt_idx;
   word_t dmem [DMEM_WORDS];
   word_t model_mem [DMEM_WORDS];
   word_t model_regs [NUM_REGS];

   // Expected bus traffic, in program order
   word_t      st_addr_q [$];
   logic [3:0] st_lane_q [$];
   word_t      st_data_q [$];
   word_t      ld_addr_q [$];
   logic [3:0] ld_lane_q [$];

   int          exp_err;
   int          err_seen;
   bit          halt_seen;
   int          halt_cycles;
   logic [31:0] lfsr_q;
   longint      timeout_ns = 0;

   core_top core_top_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .inst_i  (inst_i),
      .iaddr_o (iaddr_o),
      .data_i  (data_i),
      .daddr_o (daddr_o),
      .we_o    (we_o),
      .re_o    (re_o),
      .data_o  (data_o),
      .err_o   (err_o),
      .halt_o  (halt_o)
   );

   always #CLK_HALF clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Reporting
   //////////////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic fail_with(input string why);
      $display("%s", why);
      abort_run();
   endtask

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (exp !== got) begin
         $display("FAILED %s expected %h got %h", name, exp, got);
         abort_run();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Random source and program builder
   //////////////////////////////////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic word_t encode_inst(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic add_inst(input word_t w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   task automatic build_program();
      logic [3:0] kind;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [1:0] g;
      prog_len = 0;
      for (int r = 1; r < 8; r++) begin
         add_inst(encode_inst(ADDI, 5'd0, 5'(r), 16'(take_bits(16))));
      end
      // One undefined opcode for sure, more come at random
      add_inst(encode_inst(6'h3f, 5'd1, 5'd2, 16'h0000));
      for (int k = 0; k < N_RANDOM; k++) begin
         kind = 4'(take_bits(4));
         rs   = 5'(take_bits(3));
         rt   = 5'(take_bits(3));
         rd   = 5'(take_bits(3));
         g    = 2'(take_bits(2) % 3);
         case (kind)
            4'd0: add_inst(encode_inst(6'(13 + take_bits(6) % 51), rs, rt,
                                       16'(take_bits(16))));
            4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
               add_inst(encode_inst(6'(ADD) + 6'(take_bits(2)), rs, rt,
                                    {rd, 11'(take_bits(11))}));
            4'd6, 4'd7: add_inst(encode_inst(ADDI, rs, rt, 16'(take_bits(16))));
            4'd8, 4'd9, 4'd10:
               add_inst(encode_inst(6'(LDW) + 6'(g), rs, rt, 16'(take_bits(16))));
            4'd11, 4'd12, 4'd13, 4'd14:
               add_inst(encode_inst(6'(STW) + 6'(g), rs, rt, 16'(take_bits(16))));
            default: add_inst(encode_inst(NOP, rs, rt, 16'(take_bits(16))));
         endcase
      end
      // Dump every register to words 0 to 31
      for (int r = 0; r < NUM_REGS; r++) begin
         add_inst(encode_inst(STW, 5'd0, 5'(r), 16'(4 * r)));
      end
      halt_idx = prog_len;
      add_inst(encode_inst(HALT, 5'd0, 5'd0, 16'h0000));
      // Never to be executed
      add_inst(encode_inst(STW, 5'd0, 5'd1, 16'h00f0));
      add_inst(encode_inst(ADDI, 5'd0, 5'd2, 16'h1234));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // g is 0 for word, 1 for half, 2 for byte
   function automatic logic [3:0] lanes_for(input logic [1:0] g, input logic [1:0] ofs);
      case (g)
         2'd0: return 4'b1111;
         2'd1: return 4'b1100 >> ofs;
         default: return 4'b1000 >> ofs;
      endcase
   endfunction

   // Bytes of the item go to rising byte addresses from the offset, MSB first
   function automatic word_t place_store_data(input logic [1:0] g, input logic [1:0] ofs,
                                              input word_t v);
      word_t out;
      int    size;
      int    start;
      int    pos;
      out   = '0;
      size  = (g == 2'd0) ? 4 : ((g == 2'd1) ? 2 : 1);
      start = (g == 2'd0) ? 0 : int'(ofs);
      for (int k = 0; k < size; k++) begin
         pos = start + k;
         if (pos < 4) begin
            out[8 * (3 - pos) +: 8] = v[8 * (size - 1 - k) +: 8];
         end
      end
      return out;
   endfunction

   function automatic word_t load_mask(input logic [1:0] g);
      case (g)
         2'd0: return 32'hffff_ffff;
         2'd1: return 32'h0000_ffff;
         default: return 32'h0000_00ff;
      endcase
   endfunction

   function automatic word_t lane_bits(input logic [3:0] lanes);
      return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
   endfunction

   function automatic word_t merge_lanes(input word_t old, input word_t data,
                                         input logic [3:0] lanes);
      return (old & ~lane_bits(lanes)) | (data & lane_bits(lanes));
   endfunction

   // Distinct value for every word index
   function automatic word_t fill_word(input int i);
      return 32'(i + 1) * 32'h9e37_79b9;
   endfunction

   task automatic run_model();
      word_t      inst;
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      word_t      imm;
      word_t      res;
      word_t      addr;
      logic [1:0] g;
      logic [3:0] lanes;
      int         i;
      bit         done;
      for (int r = 0; r < NUM_REGS; r++) begin
         model_regs[r] = '0;
      end
      exp_err = 0;
      i = 0;
      done = 1'b0;
      while (i < prog_len && !done) begin
         inst = imem[i];
         op   = inst[OP_LSB +: 6];
         rs   = inst[RS_LSB +: 5];
         rt   = inst[RT_LSB +: 5];
         rd   = inst[RD_LSB +: 5];
         imm  = {{16{inst[15]}}, inst[15:0]};
         addr = model_regs[rs] + imm;
         case (op)
            HALT: done = 1'b1;
            NOP: begin
            end
            ADD, SUB, AND, XOR: begin
               case (op)
                  ADD: res = model_regs[rs] + model_regs[rt];
                  SUB: res = model_regs[rs] - model_regs[rt];
                  AND: res = model_regs[rs] & model_regs[rt];
                  default: res = model_regs[rs] ^ model_regs[rt];
               endcase
               if (rd != 0) model_regs[rd] = res;
            end
            ADDI: if (rt != 0) model_regs[rt] = addr;
            LDW, LDH, LDB: begin
               g = 2'(op - 6'(LDW));
               lanes = lanes_for(g, addr[1:0]);
               ld_addr_q.push_back(addr);
               ld_lane_q.push_back(lanes);
               if (rt != 0) model_regs[rt] = model_mem[addr[7:2]] & load_mask(g);
            end
            STW, STH, STB: begin
               g = 2'(op - 6'(STW));
               lanes = lanes_for(g, addr[1:0]);
               res = place_store_data(g, addr[1:0], model_regs[rt]);
               st_addr_q.push_back(addr);
               st_lane_q.push_back(lanes);
               st_data_q.push_back(res);
               model_mem[addr[7:2]] = merge_lanes(model_mem[addr[7:2]], res, lanes);
            end
            default: exp_err++;
         endcase
         i++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus monitor and memory models
   //////////////////////////////////////////////////////////////////////

   function automatic word_t fetch_word(input word_t addr);
      if ((addr >> 2) < prog_len) return imem[addr >> 2];
      return '0;
   endfunction

   task automatic monitor_cycle();
      word_t      e_addr;
      logic [3:0] e_lanes;
      word_t      e_data;
      word_t      mask;
      if (we_o != 4'b0000) begin
         if (st_addr_q.size() == 0) begin
            fail_with("Store on the bus with no store left in the program");
         end else begin
            e_addr  = st_addr_q.pop_front();
            e_lanes = st_lane_q.pop_front();
            e_data  = st_data_q.pop_front();
            mask    = lane_bits(e_lanes);
            check_eq("daddr_o", e_addr, daddr_o);
            check_eq("we_o", 32'(e_lanes), 32'(we_o));
            check_eq("data_o", e_data & mask, data_o & mask);
            dmem[daddr_o[7:2]] = merge_lanes(dmem[daddr_o[7:2]], data_o, we_o);
         end
      end
      if (re_o != 4'b0000) begin
         if (ld_addr_q.size() == 0) begin
            fail_with("Load on the bus with no load left in the program");
         end else begin
            e_addr  = ld_addr_q.pop_front();
            e_lanes = ld_lane_q.pop_front();
            check_eq("daddr_o", e_addr, daddr_o);
            check_eq("re_o", 32'(e_lanes), 32'(re_o));
         end
      end
      if (err_o) err_seen++;
      if (halt_o) begin
         if (!halt_seen) begin
            halt_seen = 1'b1;
            check_eq("stores left", 32'd0, 32'(st_addr_q.size()));
            check_eq("loads left", 32'd0, 32'(ld_addr_q.size()));
            check_eq("err_o cycles", 32'(exp_err), 32'(err_seen));
         end
         halt_cycles++;
      end else if (halt_seen) begin
         fail_with("halt_o fell again before reset");
      end
      // Fetch parks right behind the HALT
      if (halt_seen) check_eq("iaddr_o", 32'(4 * (halt_idx + 1)), iaddr_o);
   endtask

   // Outputs settle after the rising edge
   always @(negedge clk) begin
      if (rst_n) monitor_cycle();
      inst_i = fetch_word(iaddr_o);
      data_i = dmem[daddr_o[7:2]];
   end

   //////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////////////////////////

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      inst_i      = '0;
      data_i      = '0;
      lfsr_q      = SEED;
      halt_seen   = 1'b0;
      halt_cycles = 0;
      err_seen    = 0;
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i]      = fill_word(i);
         model_mem[i] = fill_word(i);
      end
      build_program();
      run_model();
      timeout_ns = longint'(8 * prog_len + 50) * 2 * CLK_HALF;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      while (halt_cycles < HALT_WATCH) @(posedge clk);
      for (int i = 0; i < DMEM_WORDS; i++) begin
         check_eq($sformatf("dmem[%0d]", i), model_mem[i], dmem[i]);
      end
      check_eq("err_o cycles", 32'(exp_err), 32'(err_seen));
      $display("Result: PASSED");
      $finish;
   end

   initial begin
      wait (timeout_ns > 0);
      #(timeout_ns);
      fail_with("Timeout: halt_o never rose, the core did not retire its HALT");
   end

endmodule

`default_nettype wire
